// ==== axi2umi_pkg.sv ====
// Shared widths, host addresses, UMI opcodes and command word layout for the AXI to UMI bridge
`default_nettype none

package axi2umi_pkg;

  //################################################
  // Widths
  //################################################
  localparam int aw    = 32;
  localparam int dw    = 32;
  localparam int cw    = 32;
  localparam int idw   = 4;
  // One strobe bit per data byte, also the low address bits ignored on routing
  localparam int strbw = dw / 8;

  // Source addresses that tag each request with its channel
  localparam logic [aw-1:0] wr_hostaddr = 32'h0000_0000;
  localparam logic [aw-1:0] rd_hostaddr = 32'h8000_0000;

  //################################################
  // UMI encodings
  //################################################
  localparam logic [4:0] umi_req_read   = 5'h01;
  localparam logic [4:0] umi_resp_read  = 5'h02;
  localparam logic [4:0] umi_req_write  = 5'h03;
  localparam logic [4:0] umi_resp_write = 5'h04;

  // Size is log2 of bytes per word
  localparam logic [2:0] umi_size_word = 3'd2;

  // Error codes, same values on UMI and AXI
  localparam logic [1:0] resp_ok     = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // Converter FSM states
  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_req  = 2'd1;
  localparam logic [1:0] st_wait = 2'd2;
  localparam logic [1:0] st_resp = 2'd3;

  // Command word, request view and response view
  typedef union packed {
    struct packed {
      logic [9:0] rsvd;
      logic [1:0] prot;
      logic [3:0] qos;
      logic [7:0] len;
      logic [2:0] size;
      logic [4:0] opcode;
    } req;
    struct packed {
      logic [11:0] rsvd;
      logic [1:0]  rsvd_qos;
      // Low half of the request qos field
      logic [1:0]  err;
      logic [7:0]  len;
      logic [2:0]  size;
      logic [4:0]  opcode;
    } resp;
  } umi_cmd_u;

endpackage

`default_nettype wire

// ==== umi_if.sv ====
// One UMI channel bundle with source and sink views
`default_nettype none

interface umi_if;

  // Handshake
  logic                            valid;
  logic                            ready;
  // Payload, held stable while valid and not ready
  axi2umi_pkg::umi_cmd_u           cmd;
  logic [axi2umi_pkg::aw-1:0]      dstaddr;
  logic [axi2umi_pkg::aw-1:0]      srcaddr;
  logic [axi2umi_pkg::dw-1:0]      data;

  // Driving side
  modport src (
    output valid, cmd, dstaddr, srcaddr, data,
    input  ready
  );

  // Receiving side
  modport snk (
    input  valid, cmd, dstaddr, srcaddr, data,
    output ready
  );

endinterface

`default_nettype wire

// ==== axi_wr2umi.sv ====
// AXI write converter, one AW/W pair into one UMI write request and its response into a B beat
`default_nettype none

module axi_wr2umi (
  input  wire                          clk,
  input  wire                          arst_n,
  // Write address channel
  input  wire [axi2umi_pkg::idw-1:0]   awid,
  input  wire [axi2umi_pkg::aw-1:0]    awaddr,
  input  wire                          awvalid,
  output logic                         awready,
  // Write data channel
  input  wire [axi2umi_pkg::dw-1:0]    wdata,
  input  wire [axi2umi_pkg::strbw-1:0] wstrb,
  input  wire                          wvalid,
  output logic                         wready,
  // Write response channel
  output logic [axi2umi_pkg::idw-1:0]  bid,
  output logic [1:0]                   bresp,
  output logic                         bvalid,
  input  wire                          bready,
  // UMI side
  umi_if.src                           req,
  umi_if.snk                           resp
);

  logic [1:0]                    state;
  // Channel captured flags
  logic                          aw_held;
  logic                          w_held;
  logic                          aw_hs;
  logic                          w_hs;
  logic                          both_held;
  // Stored transaction
  logic [axi2umi_pkg::idw-1:0]   awid_q;
  logic [axi2umi_pkg::aw-1:0]    awaddr_q;
  logic [axi2umi_pkg::dw-1:0]    wdata_q;
  logic [axi2umi_pkg::strbw-1:0] wstrb_q;
  logic [1:0]                    bresp_q;
  axi2umi_pkg::umi_cmd_u         req_cmd;

  //################################################
  // AXI inbound
  //################################################
  // Each channel accepted once per transaction
  assign awready = (state == axi2umi_pkg::st_idle) && !aw_held;
  assign wready  = (state == axi2umi_pkg::st_idle) && !w_held;
  assign aw_hs   = awvalid && awready;
  assign w_hs    = wvalid && wready;
  // Address and data in either order
  assign both_held = (aw_held || aw_hs) && (w_held || w_hs);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= axi2umi_pkg::st_idle;
      aw_held <= 1'b0;
      w_held  <= 1'b0;
    end else begin
      case (state)
        axi2umi_pkg::st_idle: begin
          // Flags clear as the request is launched
          aw_held <= (aw_held || aw_hs) && !both_held;
          w_held  <= (w_held || w_hs) && !both_held;
          if (both_held) state <= axi2umi_pkg::st_req;
        end
        axi2umi_pkg::st_req: begin
          if (req.valid && req.ready) state <= axi2umi_pkg::st_wait;
        end
        axi2umi_pkg::st_wait: begin
          if (resp.valid && resp.ready) state <= axi2umi_pkg::st_resp;
        end
        default: begin
          // B beat held until taken
          if (bvalid && bready) state <= axi2umi_pkg::st_idle;
        end
      endcase
    end
  end

  // Payload capture
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      awid_q   <= awid;
      awaddr_q <= awaddr;
    end
    if (w_hs) begin
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end
    if (resp.valid && resp.ready) bresp_q <= resp.cmd.resp.err;
  end

  //################################################
  // UMI request
  //################################################
  always_comb begin
    req_cmd             = '0;
    req_cmd.req.opcode  = axi2umi_pkg::umi_req_write;
    req_cmd.req.size    = axi2umi_pkg::umi_size_word;
    // Single word
    req_cmd.req.len     = 8'd0;
  end

  assign req.valid   = (state == axi2umi_pkg::st_req);
  assign req.cmd     = req_cmd;
  assign req.dstaddr = awaddr_q;
  // Strobes ride in the low source address bits
  assign req.srcaddr = {axi2umi_pkg::wr_hostaddr[axi2umi_pkg::aw-1:axi2umi_pkg::strbw], wstrb_q};
  assign req.data    = wdata_q;

  // Response taken only while waiting for it
  assign resp.ready = (state == axi2umi_pkg::st_wait);

  // B channel
  assign bvalid = (state == axi2umi_pkg::st_resp);
  assign bid    = awid_q;
  assign bresp  = bresp_q;

endmodule

`default_nettype wire

// ==== axi_rd2umi.sv ====
// AXI read converter, one AR beat into one UMI read request and its response into an R beat
`default_nettype none

module axi_rd2umi (
  input  wire                         clk,
  input  wire                         arst_n,
  // Read address channel
  input  wire [axi2umi_pkg::idw-1:0]  arid,
  input  wire [axi2umi_pkg::aw-1:0]   araddr,
  input  wire                         arvalid,
  output logic                        arready,
  // Read data channel
  output logic [axi2umi_pkg::idw-1:0] rid,
  output logic [axi2umi_pkg::dw-1:0]  rdata,
  output logic [1:0]                  rresp,
  output logic                        rlast,
  output logic                        rvalid,
  input  wire                         rready,
  // UMI side
  umi_if.src                          req,
  umi_if.snk                          resp
);

  logic [1:0]                  state;
  logic                        ar_hs;
  // Stored transaction
  logic [axi2umi_pkg::idw-1:0] arid_q;
  logic [axi2umi_pkg::aw-1:0]  araddr_q;
  logic [axi2umi_pkg::dw-1:0]  rdata_q;
  logic [1:0]                  rresp_q;
  axi2umi_pkg::umi_cmd_u       req_cmd;

  //################################################
  // Control
  //################################################
  assign arready = (state == axi2umi_pkg::st_idle);
  assign ar_hs   = arvalid && arready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= axi2umi_pkg::st_idle;
    end else begin
      case (state)
        axi2umi_pkg::st_idle: begin
          if (ar_hs) state <= axi2umi_pkg::st_req;
        end
        axi2umi_pkg::st_req: begin
          if (req.valid && req.ready) state <= axi2umi_pkg::st_wait;
        end
        axi2umi_pkg::st_wait: begin
          if (resp.valid && resp.ready) state <= axi2umi_pkg::st_resp;
        end
        default: begin
          // R beat held until taken
          if (rvalid && rready) state <= axi2umi_pkg::st_idle;
        end
      endcase
    end
  end

  // Address capture and read return
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      arid_q   <= arid;
      araddr_q <= araddr;
    end
    if (resp.valid && resp.ready) begin
      rdata_q <= resp.data;
      rresp_q <= resp.cmd.resp.err;
    end
  end

  //################################################
  // UMI request
  //################################################
  always_comb begin
    req_cmd            = '0;
    req_cmd.req.opcode = axi2umi_pkg::umi_req_read;
    req_cmd.req.size   = axi2umi_pkg::umi_size_word;
    req_cmd.req.len    = 8'd0;
  end

  assign req.valid   = (state == axi2umi_pkg::st_req);
  assign req.cmd     = req_cmd;
  assign req.dstaddr = araddr_q;
  assign req.srcaddr = axi2umi_pkg::rd_hostaddr;
  // No payload on a read
  assign req.data    = '0;

  assign resp.ready = (state == axi2umi_pkg::st_wait);

  // R channel, every beat is the last one
  assign rvalid = (state == axi2umi_pkg::st_resp);
  assign rlast  = rvalid;
  assign rid    = arid_q;
  assign rdata  = rdata_q;
  assign rresp  = rresp_q;

endmodule

`default_nettype wire

// ==== umi_req_arb.sv ====
// Two to one round-robin UMI request arbiter with grant lock under back-pressure
`default_nettype none

module umi_req_arb (
  input  wire clk,
  input  wire arst_n,
  umi_if.snk  wr_in,
  umi_if.snk  rd_in,
  umi_if.src  out
);

  // Last presented grant, high for the read side
  logic last_rd;
  // Presented request not yet accepted
  logic lock;
  logic sel_rd;

  // Grant select
  always_comb begin
    if (lock) begin
      // Keep the request on the port unchanged
      sel_rd = last_rd;
    end else if (wr_in.valid && rd_in.valid) begin
      // Tie goes to the side not granted last
      sel_rd = !last_rd;
    end else begin
      sel_rd = rd_in.valid;
    end
  end

  // Output mux
  assign out.valid   = sel_rd ? rd_in.valid   : wr_in.valid;
  assign out.cmd     = sel_rd ? rd_in.cmd     : wr_in.cmd;
  assign out.dstaddr = sel_rd ? rd_in.dstaddr : wr_in.dstaddr;
  assign out.srcaddr = sel_rd ? rd_in.srcaddr : wr_in.srcaddr;
  assign out.data    = sel_rd ? rd_in.data    : wr_in.data;

  // Ready only to the granted side
  assign wr_in.ready = !sel_rd && out.ready;
  assign rd_in.ready = sel_rd && out.ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      // Write side first after reset
      last_rd <= 1'b1;
      lock    <= 1'b0;
    end else begin
      if (out.valid) last_rd <= sel_rd;
      lock <= out.valid && !out.ready;
    end
  end

endmodule

`default_nettype wire

// ==== umi_resp_route.sv ====
// One to two UMI response router keyed on the host field of the destination address
`default_nettype none

module umi_resp_route (
  umi_if.snk in,
  umi_if.src wr_out,
  umi_if.src rd_out
);

  logic wr_hit;
  logic rd_hit;

  // Low strobe bits masked, write path puts wstrb there
  assign wr_hit = (in.dstaddr[axi2umi_pkg::aw-1:axi2umi_pkg::strbw] ==
                   axi2umi_pkg::wr_hostaddr[axi2umi_pkg::aw-1:axi2umi_pkg::strbw]);
  assign rd_hit = (in.dstaddr[axi2umi_pkg::aw-1:axi2umi_pkg::strbw] ==
                   axi2umi_pkg::rd_hostaddr[axi2umi_pkg::aw-1:axi2umi_pkg::strbw]);

  // Payload fans out to both sides
  assign wr_out.valid   = in.valid && wr_hit;
  assign wr_out.cmd     = in.cmd;
  assign wr_out.dstaddr = in.dstaddr;
  assign wr_out.srcaddr = in.srcaddr;
  assign wr_out.data    = in.data;

  assign rd_out.valid   = in.valid && rd_hit;
  assign rd_out.cmd     = in.cmd;
  assign rd_out.dstaddr = in.dstaddr;
  assign rd_out.srcaddr = in.srcaddr;
  assign rd_out.data    = in.data;

  // Stray response is swallowed
  assign in.ready = wr_hit ? wr_out.ready :
                    rd_hit ? rd_out.ready : 1'b1;

endmodule

`default_nettype wire

// ==== axi2umi.sv ====
// AXI4 slave to UMI host bridge top with separate read and write converters
`default_nettype none

module axi2umi (
  input  wire                          clk,
  input  wire                          arst_n,

  //################################################
  // AXI slave port
  //################################################
  input  wire [axi2umi_pkg::idw-1:0]   s_axi_awid,
  input  wire [axi2umi_pkg::aw-1:0]    s_axi_awaddr,
  input  wire                          s_axi_awvalid,
  output logic                         s_axi_awready,
  input  wire [axi2umi_pkg::dw-1:0]    s_axi_wdata,
  input  wire [axi2umi_pkg::strbw-1:0] s_axi_wstrb,
  input  wire                          s_axi_wvalid,
  output logic                         s_axi_wready,
  output logic [axi2umi_pkg::idw-1:0]  s_axi_bid,
  output logic [1:0]                   s_axi_bresp,
  output logic                         s_axi_bvalid,
  input  wire                          s_axi_bready,
  input  wire [axi2umi_pkg::idw-1:0]   s_axi_arid,
  input  wire [axi2umi_pkg::aw-1:0]    s_axi_araddr,
  input  wire                          s_axi_arvalid,
  output logic                         s_axi_arready,
  output logic [axi2umi_pkg::idw-1:0]  s_axi_rid,
  output logic [axi2umi_pkg::dw-1:0]   s_axi_rdata,
  output logic [1:0]                   s_axi_rresp,
  output logic                         s_axi_rlast,
  output logic                         s_axi_rvalid,
  input  wire                          s_axi_rready,

  //################################################
  // UMI host port
  //################################################
  output logic                         uhost_req_valid,
  output logic [axi2umi_pkg::cw-1:0]   uhost_req_cmd,
  output logic [axi2umi_pkg::aw-1:0]   uhost_req_dstaddr,
  output logic [axi2umi_pkg::aw-1:0]   uhost_req_srcaddr,
  output logic [axi2umi_pkg::dw-1:0]   uhost_req_data,
  input  wire                          uhost_req_ready,
  input  wire                          uhost_resp_valid,
  input  wire [axi2umi_pkg::cw-1:0]    uhost_resp_cmd,
  input  wire [axi2umi_pkg::aw-1:0]    uhost_resp_dstaddr,
  input  wire [axi2umi_pkg::aw-1:0]    uhost_resp_srcaddr,
  input  wire [axi2umi_pkg::dw-1:0]    uhost_resp_data,
  output logic                         uhost_resp_ready
);

  // Converter to arbiter
  umi_if wr_req ();
  umi_if rd_req ();
  // Router to converter
  umi_if wr_resp ();
  umi_if rd_resp ();
  // Host side bundles, tied to the plain ports below
  umi_if host_req ();
  umi_if host_resp ();

  assign uhost_req_valid   = host_req.valid;
  assign uhost_req_cmd     = host_req.cmd;
  assign uhost_req_dstaddr = host_req.dstaddr;
  assign uhost_req_srcaddr = host_req.srcaddr;
  assign uhost_req_data    = host_req.data;
  assign host_req.ready    = uhost_req_ready;

  assign host_resp.valid   = uhost_resp_valid;
  assign host_resp.cmd     = uhost_resp_cmd;
  assign host_resp.dstaddr = uhost_resp_dstaddr;
  assign host_resp.srcaddr = uhost_resp_srcaddr;
  assign host_resp.data    = uhost_resp_data;
  assign uhost_resp_ready  = host_resp.ready;

  // Write path
  axi_wr2umi u_axi_wr2umi (
    .clk     (clk),
    .arst_n  (arst_n),
    .awid    (s_axi_awid),
    .awaddr  (s_axi_awaddr),
    .awvalid (s_axi_awvalid),
    .awready (s_axi_awready),
    .wdata   (s_axi_wdata),
    .wstrb   (s_axi_wstrb),
    .wvalid  (s_axi_wvalid),
    .wready  (s_axi_wready),
    .bid     (s_axi_bid),
    .bresp   (s_axi_bresp),
    .bvalid  (s_axi_bvalid),
    .bready  (s_axi_bready),
    .req     (wr_req),
    .resp    (wr_resp)
  );

  // Read path
  axi_rd2umi u_axi_rd2umi (
    .clk     (clk),
    .arst_n  (arst_n),
    .arid    (s_axi_arid),
    .araddr  (s_axi_araddr),
    .arvalid (s_axi_arvalid),
    .arready (s_axi_arready),
    .rid     (s_axi_rid),
    .rdata   (s_axi_rdata),
    .rresp   (s_axi_rresp),
    .rlast   (s_axi_rlast),
    .rvalid  (s_axi_rvalid),
    .rready  (s_axi_rready),
    .req     (rd_req),
    .resp    (rd_resp)
  );

  // Request merge
  umi_req_arb u_umi_req_arb (
    .clk    (clk),
    .arst_n (arst_n),
    .wr_in  (wr_req),
    .rd_in  (rd_req),
    .out    (host_req)
  );

  // Response split
  umi_resp_route u_umi_resp_route (
    .in     (host_resp),
    .wr_out (wr_resp),
    .rd_out (rd_resp)
  );

endmodule

`default_nettype wire

// ==== axi2umi_properties.sv ====
// Protocol, encoding and ordering checks for the AXI to UMI bridge, bound into the top level
`default_nettype none

module axi2umi_properties (
  input wire                        clk,
  input wire                        arst_n,
  input wire                        s_axi_awvalid,
  input wire                        s_axi_awready,
  input wire                        s_axi_arvalid,
  input wire                        s_axi_arready,
  input wire [axi2umi_pkg::idw-1:0] s_axi_bid,
  input wire [1:0]                  s_axi_bresp,
  input wire                        s_axi_bvalid,
  input wire                        s_axi_bready,
  input wire [axi2umi_pkg::idw-1:0] s_axi_rid,
  input wire [axi2umi_pkg::dw-1:0]  s_axi_rdata,
  input wire [1:0]                  s_axi_rresp,
  input wire                        s_axi_rlast,
  input wire                        s_axi_rvalid,
  input wire                        s_axi_rready,
  input wire                        uhost_req_valid,
  input wire [axi2umi_pkg::cw-1:0]  uhost_req_cmd,
  input wire [axi2umi_pkg::aw-1:0]  uhost_req_dstaddr,
  input wire [axi2umi_pkg::aw-1:0]  uhost_req_srcaddr,
  input wire [axi2umi_pkg::dw-1:0]  uhost_req_data,
  input wire                        uhost_req_ready,
  // Converter to arbiter handshakes
  input wire                        wr_valid,
  input wire                        wr_ready,
  input wire                        rd_valid,
  input wire                        rd_ready
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned           fail_count = 0;
  axi2umi_pkg::umi_cmd_u req_cmd;
  logic                  wr_host;
  // First AW or AR taken since reset
  logic                  seen_in;
  // Side already passed over once while waiting
  logic                  wr_skipped;
  logic                  rd_skipped;

  assign req_cmd = uhost_req_cmd;
  assign wr_host = (uhost_req_srcaddr[axi2umi_pkg::aw-1:axi2umi_pkg::strbw] ==
                    axi2umi_pkg::wr_hostaddr[axi2umi_pkg::aw-1:axi2umi_pkg::strbw]);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      seen_in    <= 1'b0;
      wr_skipped <= 1'b0;
      rd_skipped <= 1'b0;
    end else begin
      if ((s_axi_awvalid && s_axi_awready) || (s_axi_arvalid && s_axi_arready)) seen_in <= 1'b1;
      if (wr_valid && wr_ready) wr_skipped <= 1'b0;
      else if (rd_valid && rd_ready && wr_valid) wr_skipped <= 1'b1;
      if (rd_valid && rd_ready) rd_skipped <= 1'b0;
      else if (wr_valid && wr_ready && rd_valid) rd_skipped <= 1'b1;
    end
  end

  //################################################
  // Request encoding
  //################################################
  req_opcode_a: assert property (@(posedge clk) disable iff (!arst_n)
    uhost_req_valid && uhost_req_ready |->
      (wr_host == (req_cmd.req.opcode == axi2umi_pkg::umi_req_write)))
    else begin fail_count++; $error("write opcode and write host address disagree"); end

  rd_srcaddr_a: assert property (@(posedge clk) disable iff (!arst_n)
    uhost_req_valid && uhost_req_ready && (req_cmd.req.opcode == axi2umi_pkg::umi_req_read)
      |-> uhost_req_srcaddr == axi2umi_pkg::rd_hostaddr)
    else begin fail_count++; $error("read request without the read host address"); end

  //################################################
  // Stability under back-pressure
  //################################################
  req_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
    uhost_req_valid && !uhost_req_ready |=> uhost_req_valid &&
      $stable({uhost_req_cmd, uhost_req_dstaddr, uhost_req_srcaddr, uhost_req_data}))
    else begin fail_count++; $error("UMI request changed before it was accepted"); end

  b_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable({s_axi_bid, s_axi_bresp}))
    else begin fail_count++; $error("B beat changed before it was accepted"); end

  r_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid &&
      $stable({s_axi_rid, s_axi_rdata, s_axi_rresp, s_axi_rlast}))
    else begin fail_count++; $error("R beat changed before it was accepted"); end

  //################################################
  // Fairness and reset
  //################################################
  wr_fair_a: assert property (@(posedge clk) disable iff (!arst_n)
    rd_valid && rd_ready && wr_valid |-> !wr_skipped)
    else begin fail_count++; $error("write request passed over twice in a row"); end

  rd_fair_a: assert property (@(posedge clk) disable iff (!arst_n)
    wr_valid && wr_ready && rd_valid |-> !rd_skipped)
    else begin fail_count++; $error("read request passed over twice in a row"); end

  reset_quiet_a: assert property (@(posedge clk) disable iff (!arst_n)
    !seen_in |-> !s_axi_bvalid && !s_axi_rvalid && !uhost_req_valid)
    else begin fail_count++; $error("output valid raised before any inbound handshake"); end

endmodule

bind axi2umi axi2umi_properties u_props (
  .*,
  .wr_valid (wr_req.valid),
  .wr_ready (wr_req.ready),
  .rd_valid (rd_req.valid),
  .rd_ready (rd_req.ready)
);

`default_nettype wire

// ==== tb_axi2umi.sv ====
// Testbench for the AXI4 to UMI bridge with UMI device model, memory scoreboard and timeout
`default_nettype none

module tb_axi2umi;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_trans    = 40;
  localparam int max_cycles = 2000;

  // Pending UMI response in the device model
  typedef struct packed {
    logic [31:0] cmd;
    logic [31:0] dst;
    logic [31:0] data;
    logic [31:0] due;
  } umi_rsp_t;

  logic                                clk = 1'b0;
  logic                                arst_n;
  logic [axi2umi_pkg::idw-1:0]         s_axi_awid = '0;
  logic [axi2umi_pkg::aw-1:0]          s_axi_awaddr = '0;
  logic                                s_axi_awvalid = 1'b0;
  logic                                s_axi_awready;
  logic [axi2umi_pkg::dw-1:0]          s_axi_wdata = '0;
  logic [axi2umi_pkg::strbw-1:0]       s_axi_wstrb = '0;
  logic                                s_axi_wvalid = 1'b0;
  logic                                s_axi_wready;
  logic [axi2umi_pkg::idw-1:0]         s_axi_bid;
  logic [1:0]                          s_axi_bresp;
  logic                                s_axi_bvalid;
  logic                                s_axi_bready = 1'b0;
  logic [axi2umi_pkg::idw-1:0]         s_axi_arid = '0;
  logic [axi2umi_pkg::aw-1:0]          s_axi_araddr = '0;
  logic                                s_axi_arvalid = 1'b0;
  logic                                s_axi_arready;
  logic [axi2umi_pkg::idw-1:0]         s_axi_rid;
  logic [axi2umi_pkg::dw-1:0]          s_axi_rdata;
  logic [1:0]                          s_axi_rresp;
  logic                                s_axi_rlast;
  logic                                s_axi_rvalid;
  logic                                s_axi_rready = 1'b0;
  logic                                uhost_req_valid;
  logic [axi2umi_pkg::cw-1:0]          uhost_req_cmd;
  logic [axi2umi_pkg::aw-1:0]          uhost_req_dstaddr;
  logic [axi2umi_pkg::aw-1:0]          uhost_req_srcaddr;
  logic [axi2umi_pkg::dw-1:0]          uhost_req_data;
  logic                                uhost_req_ready = 1'b0;
  logic                                uhost_resp_valid = 1'b0;
  logic [axi2umi_pkg::cw-1:0]          uhost_resp_cmd = '0;
  logic [axi2umi_pkg::aw-1:0]          uhost_resp_dstaddr = '0;
  logic [axi2umi_pkg::aw-1:0]          uhost_resp_srcaddr = '0;
  logic [axi2umi_pkg::dw-1:0]          uhost_resp_data = '0;
  logic                                uhost_resp_ready;

  // Device memory and expected memory with one word per index
  logic [31:0]  dev_mem [16];
  logic [31:0]  exp_mem [16];
  // Index owned by a master with a transaction in flight
  logic [15:0]  busy = '0;
  umi_rsp_t     pend_q [$];
  logic [31:0]  dev_cycle = '0;
  int unsigned  cycles = 0;

  axi2umi dut_i (.*);

  always #10 clk = ~clk;

  //################################################
  // Helpers
  //################################################
  task automatic abort_run(input string why);
    $display("=== FAIL ===");
    $fatal(1, "%s", why);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    abort_run($sformatf("error at %0t ns: %s expected %h, actual %h",
                        $time, name, expected, actual));
  endtask

  // Word index in bits 5:2 and error region on bit 8
  function automatic logic [31:0] make_addr(input logic [3:0] idx, input logic err);
    return {23'd0, err, 2'b00, idx, 2'b00};
  endfunction

  // Byte lanes with a strobe take the new data
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0] strb);
    logic [31:0] merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) merged[8*b +: 8] = new_word[8*b +: 8];
    end
    return merged;
  endfunction

  function automatic logic [3:0] pick_free_index();
    logic [3:0] idx;
    idx = 4'($urandom_range(15));
    while (busy[idx]) idx = 4'($urandom_range(15));
    return idx;
  endfunction

  //################################################
  // AXI masters
  //################################################
  task automatic send_aw(input logic [3:0] id, input logic [31:0] addr);
    @(negedge clk);
    repeat ($urandom_range(3)) @(negedge clk);
    s_axi_awid    <= id;
    s_axi_awaddr  <= addr;
    s_axi_awvalid <= 1'b1;
    do @(posedge clk); while (!s_axi_awready);
    @(negedge clk);
    s_axi_awvalid <= 1'b0;
  endtask

  task automatic send_w(input logic [31:0] data, input logic [3:0] strb);
    @(negedge clk);
    repeat ($urandom_range(3)) @(negedge clk);
    s_axi_wdata  <= data;
    s_axi_wstrb  <= strb;
    s_axi_wvalid <= 1'b1;
    do @(posedge clk); while (!s_axi_wready);
    @(negedge clk);
    s_axi_wvalid <= 1'b0;
  endtask

  task automatic run_writes();
    logic [3:0]  idx;
    logic        err;
    logic [3:0]  id;
    logic [31:0] data;
    logic [3:0]  strb;
    repeat (n_trans / 2) begin
      idx       = pick_free_index();
      busy[idx] = 1'b1;
      err       = ($urandom_range(3) == 0);
      id        = 4'($urandom);
      data      = $urandom;
      strb      = 4'($urandom);
      // Separate AW and W gaps let either lead
      fork
        send_aw(id, make_addr(idx, err));
        send_w(data, strb);
      join
      forever begin
        @(negedge clk);
        s_axi_bready <= ($urandom_range(3) != 0);
        @(posedge clk);
        if (s_axi_bvalid && s_axi_bready) break;
      end
      assert (s_axi_bid == id)
        else report_mismatch("s_axi_bid", 32'(id), 32'(s_axi_bid));
      assert (s_axi_bresp == (err ? axi2umi_pkg::resp_slverr : axi2umi_pkg::resp_ok))
        else report_mismatch("s_axi_bresp", {31'd0, err} << 1, 32'(s_axi_bresp));
      if (!err) exp_mem[idx] = merge_bytes(exp_mem[idx], data, strb);
      busy[idx] = 1'b0;
    end
  endtask

  task automatic run_reads();
    logic [3:0]  idx;
    logic        err;
    logic [3:0]  id;
    logic [31:0] expected;
    repeat (n_trans / 2) begin
      idx       = pick_free_index();
      busy[idx] = 1'b1;
      err       = ($urandom_range(3) == 0);
      id        = 4'($urandom);
      // No write can touch this word while it is held
      expected  = exp_mem[idx];
      @(negedge clk);
      repeat ($urandom_range(3)) @(negedge clk);
      s_axi_arid    <= id;
      s_axi_araddr  <= make_addr(idx, err);
      s_axi_arvalid <= 1'b1;
      do @(posedge clk); while (!s_axi_arready);
      @(negedge clk);
      s_axi_arvalid <= 1'b0;
      forever begin
        @(negedge clk);
        s_axi_rready <= ($urandom_range(3) != 0);
        @(posedge clk);
        if (s_axi_rvalid && s_axi_rready) break;
      end
      assert (s_axi_rid == id)
        else report_mismatch("s_axi_rid", 32'(id), 32'(s_axi_rid));
      assert (s_axi_rlast)
        else report_mismatch("s_axi_rlast", 32'd1, 32'(s_axi_rlast));
      assert (s_axi_rresp == (err ? axi2umi_pkg::resp_slverr : axi2umi_pkg::resp_ok))
        else report_mismatch("s_axi_rresp", {31'd0, err} << 1, 32'(s_axi_rresp));
      if (!err) begin
        assert (s_axi_rdata == expected)
          else report_mismatch("s_axi_rdata", expected, s_axi_rdata);
      end
      busy[idx] = 1'b0;
    end
  endtask

  //################################################
  // UMI device model
  //################################################
  // Accept requests and retire taken responses
  always @(posedge clk) begin : umi_accept
    axi2umi_pkg::umi_cmd_u req_view;
    axi2umi_pkg::umi_cmd_u rsp_view;
    umi_rsp_t              rsp;
    logic [3:0]            word;
    if (uhost_req_valid && uhost_req_ready) begin
      req_view             = uhost_req_cmd;
      word                 = uhost_req_dstaddr[5:2];
      rsp_view             = '0;
      rsp_view.resp.size   = req_view.req.size;
      rsp_view.resp.err    = uhost_req_dstaddr[8] ? axi2umi_pkg::resp_slverr
                                                  : axi2umi_pkg::resp_ok;
      if (req_view.req.opcode == axi2umi_pkg::umi_req_write) begin
        rsp_view.resp.opcode = axi2umi_pkg::umi_resp_write;
        // Strobes come from the low source address bits
        if (!uhost_req_dstaddr[8]) begin
          dev_mem[word] = merge_bytes(dev_mem[word], uhost_req_data,
                                      uhost_req_srcaddr[3:0]);
        end
      end else begin
        rsp_view.resp.opcode = axi2umi_pkg::umi_resp_read;
      end
      rsp.cmd  = rsp_view;
      rsp.dst  = uhost_req_srcaddr;
      rsp.data = dev_mem[word];
      rsp.due  = dev_cycle + $urandom_range(5);
      pend_q.push_back(rsp);
    end
    if (uhost_resp_valid && uhost_resp_ready) void'(pend_q.pop_front());
    dev_cycle = dev_cycle + 32'd1;
  end

  // Random request back-pressure and in-order responses
  always @(negedge clk) begin : umi_present
    uhost_req_ready <= ($urandom_range(3) != 0);
    if (pend_q.size() != 0 && pend_q[0].due <= dev_cycle) begin
      uhost_resp_valid   <= 1'b1;
      uhost_resp_cmd     <= pend_q[0].cmd;
      uhost_resp_dstaddr <= pend_q[0].dst;
      uhost_resp_data    <= pend_q[0].data;
    end else begin
      uhost_resp_valid <= 1'b0;
    end
  end

  //################################################
  // Run control
  //################################################
  always @(posedge clk) begin
    cycles++;
    if (cycles > max_cycles) begin
      abort_run("timeout, transactions did not complete within the cycle limit");
    end else if (dut_i.u_props.fail_count != 0) begin
      abort_run("a bus protocol property failed");
    end
  end

  initial begin
    void'($urandom(71233));
    arst_n = 1'b0;
    for (int i = 0; i < 16; i++) begin
      dev_mem[i] = 32'h5a5a_0000 | (i << 2);
      exp_mem[i] = 32'h5a5a_0000 | (i << 2);
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n <= 1'b1;
    fork
      run_writes();
      run_reads();
    join
    // Property results of the last edge settle by the falling edge
    @(negedge clk);
    if (dut_i.u_props.fail_count == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      abort_run("a bus protocol property failed");
    end
  end

endmodule

`default_nettype wire

// ==== flist.f ====
axi2umi_pkg.sv
umi_if.sv
axi_wr2umi.sv
axi_rd2umi.sv
umi_req_arb.sv
umi_resp_route.sv
axi2umi.sv
axi2umi_properties.sv
tb_axi2umi.sv

// ==== Makefile ====
# Verilator build and run for the AXI to UMI bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_axi2umi
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= === PASS ===

SRCS := $(shell grep -v '^+' $(FLIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	$(SIM) $(RUN_ARGS) | awk -v msg="$(PASS_MSG)" '{ print } $$0 == msg { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
